// File: vpu_pkg.sv
package vpu_pkg;

    // stream geometry
    localparam int LANES      = 4;   // samples per vector word
    localparam int NUM_COL    = 4;   // mac columns in the chain
    localparam int SAMPLE_W   = 16;

    // buffering
    localparam int FIFO_DEPTH = 16;
    localparam int CNT_W      = 5;   // holds 0..FIFO_DEPTH

    // apb register map, word addresses
    localparam int APB_AW     = 5;
    localparam int APB_DW     = 32;
    localparam int ADDR_CTRL  = 0;   // bit 0 = run
    localparam int ADDR_BIAS0 = 1;   // bias lane k at 1+k
    localparam int ADDR_WGT0  = 5;   // weight col c lane k at 5+c*LANES+k
    localparam int NUM_REGS   = 21;

    typedef logic [SAMPLE_W-1:0] sample_t;
    typedef logic [CNT_W-1:0]    fifo_cnt_t;
    typedef logic [APB_AW-1:0]   apb_addr_t;
    typedef logic [APB_DW-1:0]   apb_data_t;

    typedef struct packed {
        sample_t [LANES-1:0] data;
    } lane_vec_t;

    // bundle passed from column to column
    typedef struct packed {
        logic      valid;
        lane_vec_t sample;
        lane_vec_t psum;   // running bias + sum of products
    } col_bus_t;

    typedef struct packed {
        logic      sel;
        logic      enable;
        logic      write;
        apb_addr_t addr;
        apb_data_t wdata;
    } apb_req_t;

    typedef struct packed {
        logic      ready;
        apb_data_t rdata;
    } apb_rsp_t;

    typedef lane_vec_t [NUM_COL-1:0] wgt_array_t;

endpackage

// File: sync_fifo.sv
module sync_fifo (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_push,
    input  logic               i_pop,
    input  vpu_pkg::col_bus_t  i_din,
    output vpu_pkg::col_bus_t  o_dout,
    output logic               o_empty,
    output logic               o_full,
    output vpu_pkg::fifo_cnt_t o_count
);

    vpu_pkg::col_bus_t                      mem [vpu_pkg::FIFO_DEPTH];
    logic [$clog2(vpu_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(vpu_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    vpu_pkg::fifo_cnt_t                     count;

    // storage
    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_din;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or push+pop
            endcase
        end
    end

    assign o_dout  = mem[rd_ptr];   // head entry, first-word fall-through
    assign o_empty = (count == '0);
    assign o_full  = (count == vpu_pkg::fifo_cnt_t'(vpu_pkg::FIFO_DEPTH));
    assign o_count = count;

    // the writer and reader are expected to respect the flags
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!i_rst_n) i_push |-> !o_full
    );

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!i_rst_n) i_pop |-> !o_empty
    );

endmodule

// File: stream_ingress.sv
module stream_ingress (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_run,
    input  vpu_pkg::lane_vec_t i_bias,
    input  logic               i_advance,
    input  vpu_pkg::lane_vec_t i_tdata,
    input  logic               i_tvalid,
    output logic               o_tready,
    output vpu_pkg::col_bus_t  o_bus
);

    logic               fifo_push;
    logic               fifo_pop;
    logic               fifo_empty;
    logic               fifo_full;
    vpu_pkg::col_bus_t  fifo_din;
    vpu_pkg::col_bus_t  fifo_dout;
    logic               valid_q;
    vpu_pkg::lane_vec_t sample_q;
    vpu_pkg::lane_vec_t psum_q;

    // accept only while running and there is room
    assign o_tready  = i_run && !fifo_full;
    assign fifo_push = i_tvalid && o_tready;
    assign fifo_pop  = i_advance && !fifo_empty;

    assign fifo_din = '{valid: 1'b1, sample: i_tdata, psum: '0};

    sync_fifo u_fifo (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_push  (fifo_push),
        .i_pop   (fifo_pop),
        .i_din   (fifo_din),
        .o_dout  (fifo_dout),
        .o_empty (fifo_empty),
        .o_full  (fifo_full),
        .o_count ()
    );

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else if (i_advance) begin
            valid_q <= !fifo_empty;   // bubble when nothing buffered
        end
    end

    // payload only changes with a real word
    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            sample_q <= fifo_dout.sample;
            psum_q   <= i_bias;   // accumulation starts from bias
        end
    end

    assign o_bus = '{valid: valid_q, sample: sample_q, psum: psum_q};

endmodule

// File: mac_column.sv
module mac_column (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_advance,
    input  vpu_pkg::lane_vec_t i_weight,
    input  vpu_pkg::col_bus_t  i_bus,
    output vpu_pkg::col_bus_t  o_bus
);

    vpu_pkg::lane_vec_t psum_nxt;
    logic               valid_q;
    vpu_pkg::lane_vec_t sample_q;
    vpu_pkg::lane_vec_t psum_q;

    // per lane multiply-accumulate, wraps at SAMPLE_W bits
    always_comb begin
        for (int k = 0; k < vpu_pkg::LANES; k++) begin
            psum_nxt.data[k] = i_bus.psum.data[k]
                             + i_bus.sample.data[k] * i_weight.data[k];
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else if (i_advance) begin
            valid_q <= i_bus.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_advance) begin
            sample_q <= i_bus.sample;   // sample passes through unchanged
            psum_q   <= psum_nxt;
        end
    end

    assign o_bus = '{valid: valid_q, sample: sample_q, psum: psum_q};

    // whole chain freezes together when egress runs short of room
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        !i_advance |=> (o_bus.valid == $past(o_bus.valid))
                    && (!o_bus.valid || $stable(o_bus))
    );

endmodule

// File: stream_egress.sv
module stream_egress (
    input  logic               clk,
    input  logic               i_rst_n,
    input  vpu_pkg::col_bus_t  i_bus,
    output logic               o_advance,
    output vpu_pkg::lane_vec_t o_tdata,
    output logic               o_tvalid,
    input  logic               i_tready
);

    logic               fifo_push;
    logic               fifo_pop;
    logic               fifo_empty;
    vpu_pkg::col_bus_t  fifo_dout;
    vpu_pkg::fifo_cnt_t fifo_count;

    // keep room for every stage that may still hold a word
    assign o_advance = (fifo_count <= vpu_pkg::fifo_cnt_t'(vpu_pkg::FIFO_DEPTH
                                                          - (vpu_pkg::NUM_COL + 1)));

    assign fifo_push = o_advance && i_bus.valid;
    assign fifo_pop  = i_tready && !fifo_empty;

    sync_fifo u_fifo (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_push  (fifo_push),
        .i_pop   (fifo_pop),
        .i_din   (i_bus),
        .o_dout  (fifo_dout),
        .o_empty (fifo_empty),
        .o_full  (),
        .o_count (fifo_count)
    );

    // head stays put until popped, so data holds under back-pressure
    assign o_tvalid = !fifo_empty;
    assign o_tdata  = fifo_dout.psum;   // finished dot product

    a_count_bound: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        fifo_count <= vpu_pkg::fifo_cnt_t'(vpu_pkg::FIFO_DEPTH)
    );

endmodule

// File: coef_regs.sv
module coef_regs (
    input  logic                clk,
    input  logic                i_rst_n,
    input  vpu_pkg::apb_req_t   i_apb,
    output vpu_pkg::apb_rsp_t   o_apb,
    output logic                o_run,
    output vpu_pkg::lane_vec_t  o_bias,
    output vpu_pkg::wgt_array_t o_weights
);

    logic                access;
    logic                hit;
    logic                wr_en;
    vpu_pkg::apb_data_t  rdata;
    logic                run_q;
    vpu_pkg::lane_vec_t  bias_q;
    vpu_pkg::wgt_array_t wgt_q;

    assign access = i_apb.sel && i_apb.enable;   // zero wait states
    assign hit    = (i_apb.addr < vpu_pkg::apb_addr_t'(vpu_pkg::NUM_REGS));
    assign wr_en  = access && i_apb.write && hit;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_q  <= 1'b0;
            bias_q <= '0;
            wgt_q  <= '0;
        end else if (wr_en) begin
            if (i_apb.addr == vpu_pkg::apb_addr_t'(vpu_pkg::ADDR_CTRL)) begin
                run_q <= i_apb.wdata[0];
            end
            for (int k = 0; k < vpu_pkg::LANES; k++) begin
                if (i_apb.addr == vpu_pkg::apb_addr_t'(vpu_pkg::ADDR_BIAS0 + k)) begin
                    bias_q.data[k] <= i_apb.wdata[vpu_pkg::SAMPLE_W-1:0];
                end
            end
            for (int c = 0; c < vpu_pkg::NUM_COL; c++) begin
                for (int k = 0; k < vpu_pkg::LANES; k++) begin
                    if (i_apb.addr == vpu_pkg::apb_addr_t'(vpu_pkg::ADDR_WGT0
                                      + c * vpu_pkg::LANES + k)) begin
                        wgt_q[c].data[k] <= i_apb.wdata[vpu_pkg::SAMPLE_W-1:0];
                    end
                end
            end
        end
    end

    // read mux, unmapped words return zero
    always_comb begin
        rdata = '0;
        if (hit) begin
            if (i_apb.addr == vpu_pkg::apb_addr_t'(vpu_pkg::ADDR_CTRL)) begin
                rdata[0] = run_q;
            end
            for (int k = 0; k < vpu_pkg::LANES; k++) begin
                if (i_apb.addr == vpu_pkg::apb_addr_t'(vpu_pkg::ADDR_BIAS0 + k)) begin
                    rdata[vpu_pkg::SAMPLE_W-1:0] = bias_q.data[k];
                end
            end
            for (int c = 0; c < vpu_pkg::NUM_COL; c++) begin
                for (int k = 0; k < vpu_pkg::LANES; k++) begin
                    if (i_apb.addr == vpu_pkg::apb_addr_t'(vpu_pkg::ADDR_WGT0
                                      + c * vpu_pkg::LANES + k)) begin
                        rdata[vpu_pkg::SAMPLE_W-1:0] = wgt_q[c].data[k];
                    end
                end
            end
        end
    end

    assign o_apb     = '{ready: access, rdata: rdata};
    assign o_run     = run_q;   // gates stream input ready
    assign o_bias    = bias_q;
    assign o_weights = wgt_q;

    // access phase must follow a selected setup phase
    a_enable_needs_sel: assert property (
        @(posedge clk) disable iff (!i_rst_n) i_apb.enable |-> i_apb.sel
    );

endmodule

// File: data_path.sv
module data_path (
    input  logic               clk,
    input  logic               i_rst_n,
    // configuration
    input  vpu_pkg::apb_req_t  i_apb,
    output vpu_pkg::apb_rsp_t  o_apb,
    // stream in
    input  vpu_pkg::lane_vec_t i_tdata,
    input  logic               i_tvalid,
    output logic               o_tready,
    // stream out
    output vpu_pkg::lane_vec_t o_tdata,
    output logic               o_tvalid,
    input  logic               i_tready
);

    logic                run;
    logic                advance;   // common stage enable
    vpu_pkg::lane_vec_t  bias;
    vpu_pkg::wgt_array_t weights;
    vpu_pkg::col_bus_t   chain [vpu_pkg::NUM_COL+1];   // ingress, columns, egress

    coef_regs u_regs (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_apb     (i_apb),
        .o_apb     (o_apb),
        .o_run     (run),
        .o_bias    (bias),
        .o_weights (weights)
    );

    stream_ingress u_ingress (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_run     (run),
        .i_bias    (bias),
        .i_advance (advance),
        .i_tdata   (i_tdata),
        .i_tvalid  (i_tvalid),
        .o_tready  (o_tready),
        .o_bus     (chain[0])
    );

    // one column per weight vector
    for (genvar c = 0; c < vpu_pkg::NUM_COL; c++) begin : g_col
        mac_column u_col (
            .clk       (clk),
            .i_rst_n   (i_rst_n),
            .i_advance (advance),
            .i_weight  (weights[c]),
            .i_bus     (chain[c]),
            .o_bus     (chain[c+1])
        );
    end

    stream_egress u_egress (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_bus     (chain[vpu_pkg::NUM_COL]),
        .o_advance (advance),
        .o_tdata   (o_tdata),
        .o_tvalid  (o_tvalid),
        .i_tready  (i_tready)
    );

endmodule

// File: tb_data_path.sv
module tb_data_path;

    localparam int N_CASES = 3;
    localparam int N_WORDS = 4;     // words listed per case
    localparam int TIMEOUT = 400;   // cycles allowed per wait

    typedef struct packed {
        vpu_pkg::lane_vec_t               bias;
        vpu_pkg::wgt_array_t              wgt;
        vpu_pkg::lane_vec_t [N_WORDS-1:0] words;
        logic [3:0]                       reps;   // passes over the word list
        logic                             bp;     // random output back-pressure
    } case_t;

    logic                clk;
    logic                i_rst_n;
    vpu_pkg::apb_req_t   i_apb;
    vpu_pkg::apb_rsp_t   o_apb;
    vpu_pkg::lane_vec_t  i_tdata;
    logic                i_tvalid;
    logic                o_tready;
    vpu_pkg::lane_vec_t  o_tdata;
    logic                o_tvalid;
    logic                i_tready;

    case_t               cases [N_CASES];
    vpu_pkg::lane_vec_t  exp_q [$];   // outputs still owed by the DUT
    logic [31:0]         lfsr;
    int                  stall_cycles;   // cycles an input word waited for ready

    data_path i_dut (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_apb    (i_apb),
        .o_apb    (o_apb),
        .i_tdata  (i_tdata),
        .i_tvalid (i_tvalid),
        .o_tready (o_tready),
        .o_tdata  (o_tdata),
        .o_tvalid (o_tvalid),
        .i_tready (i_tready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};   // one step per bit
        end
    endtask

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_vec(input string name, input vpu_pkg::lane_vec_t got,
                             input vpu_pkg::lane_vec_t exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input vpu_pkg::apb_data_t got,
                              input vpu_pkg::apb_data_t exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // bias plus weight times sample over all columns, 16 bit wrap
    function automatic vpu_pkg::lane_vec_t dot_ref(input case_t tc,
                                                   input vpu_pkg::lane_vec_t x);
        vpu_pkg::lane_vec_t y;
        for (int k = 0; k < vpu_pkg::LANES; k++) begin
            y.data[k] = tc.bias.data[k];
            for (int c = 0; c < vpu_pkg::NUM_COL; c++) begin
                y.data[k] = y.data[k] + x.data[k] * tc.wgt[c].data[k];
            end
        end
        return y;
    endfunction

    // setup then access phase, returns read data
    task automatic apb_xfer(input logic wr, input vpu_pkg::apb_addr_t addr,
                            input vpu_pkg::apb_data_t wdata,
                            output vpu_pkg::apb_data_t rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        i_apb = '{sel: 1'b1, enable: 1'b0, write: wr, addr: addr, wdata: wdata};
        @(negedge clk);
        check_bit("o_apb.ready", o_apb.ready, 1'b0);   // still in setup phase
        i_apb.enable = 1'b1;
        @(posedge clk);
        while (!o_apb.ready) begin
            if (waited == TIMEOUT) begin
                fail_now("apb access never completed");
            end
            waited++;
            @(posedge clk);
        end
        rdata = o_apb.rdata;
        @(negedge clk);
        i_apb = '0;
    endtask

    task automatic write_verify(input int addr, input vpu_pkg::apb_data_t wdata,
                                input vpu_pkg::apb_data_t exp_rd);
        vpu_pkg::apb_data_t rd;
        apb_xfer(1'b1, vpu_pkg::apb_addr_t'(addr), wdata, rd);
        apb_xfer(1'b0, vpu_pkg::apb_addr_t'(addr), '0, rd);
        check_data($sformatf("apb word %0d", addr), rd, exp_rd);
    endtask

    task automatic send_words(input case_t tc);
        int waited;
        for (int r = 0; r < int'(tc.reps); r++) begin
            for (int w = 0; w < N_WORDS; w++) begin
                @(negedge clk);
                i_tvalid = 1'b1;
                i_tdata  = tc.words[w];
                waited   = 0;
                while (!o_tready) begin   // held until accepted
                    if (waited == TIMEOUT) begin
                        fail_now("input word was never accepted");
                    end
                    waited++;
                    stall_cycles++;
                    @(negedge clk);
                end
            end
        end
        @(negedge clk);
        i_tvalid = 1'b0;
    endtask

    task automatic collect_words(input logic bp);
        logic [31:0]        rb;
        vpu_pkg::lane_vec_t exp_w;
        int                 waited;
        waited = 0;
        rb     = '1;
        while (exp_q.size() > 0) begin
            @(negedge clk);
            if (bp) begin
                take_bits(2, rb);
            end
            i_tready = !bp || (rb[1:0] == 2'b11);   // quarter rate under bp
            if (o_tvalid && i_tready) begin
                exp_w  = exp_q.pop_front();
                check_vec("o_tdata", o_tdata, exp_w);
                waited = 0;
            end else begin
                if (waited == TIMEOUT) begin
                    fail_now("expected output word never arrived");
                end
                waited++;
            end
        end
        @(negedge clk);
        i_tready = 1'b1;
    endtask

    task automatic run_case(input case_t tc);
        for (int k = 0; k < vpu_pkg::LANES; k++) begin
            write_verify(vpu_pkg::ADDR_BIAS0 + k, {16'ha5a5, tc.bias.data[k]},
                         {16'h0, tc.bias.data[k]});
        end
        for (int c = 0; c < vpu_pkg::NUM_COL; c++) begin
            for (int k = 0; k < vpu_pkg::LANES; k++) begin
                write_verify(vpu_pkg::ADDR_WGT0 + c * vpu_pkg::LANES + k,
                             {16'ha5a5, tc.wgt[c].data[k]}, {16'h0, tc.wgt[c].data[k]});
            end
        end
        write_verify(vpu_pkg::ADDR_CTRL, 32'h1, 32'h1);
        for (int r = 0; r < int'(tc.reps); r++) begin
            for (int w = 0; w < N_WORDS; w++) begin
                exp_q.push_back(dot_ref(tc, tc.words[w]));
            end
        end
        stall_cycles = 0;
        fork
            send_words(tc);
            collect_words(tc.bp);
        join
        if (tc.bp && stall_cycles == 0) begin
            fail_now("input stream was never held off by a full core");
        end
        repeat (8) begin   // nothing extra may follow
            @(negedge clk);
            check_bit("o_tvalid", o_tvalid, 1'b0);
        end
    endtask

    task automatic load_table();
        // column 0 passes samples, others zero
        cases[0].bias  = 64'h0004_0003_0002_0001;
        cases[0].wgt   = {64'h0, 64'h0, 64'h0, 64'h0001_0001_0001_0001};
        cases[0].words = {64'h0010_0020_0030_0040, 64'hffff_0000_7fff_8000,
                          64'h1234_5678_9abc_def0, 64'h0001_0001_0001_0001};
        cases[0].reps  = 4'd1;
        cases[0].bp    = 1'b0;
        // large products that wrap
        cases[1].bias  = 64'h0100_0200_0300_0400;
        cases[1].wgt   = {64'h0007_0005_0003_0002, 64'h0100_0010_0001_1000,
                          64'hffff_0002_8000_0003, 64'h0001_0002_0003_0004};
        cases[1].words = {64'h0003_0005_0007_0009, 64'hfedc_ba98_7654_3210,
                          64'h0000_ffff_0000_ffff, 64'h4000_2000_1000_0800};
        cases[1].reps  = 4'd1;
        cases[1].bp    = 1'b0;
        // long burst against a slow sink, fills both fifos
        cases[2].bias  = 64'hffff_8000_0000_1234;
        cases[2].wgt   = {64'h0002_0002_0002_0002, 64'hffff_ffff_ffff_ffff,
                          64'h0003_0004_0005_0006, 64'h0011_0022_0033_0044};
        cases[2].words = {64'h0102_0304_0506_0708, 64'h0a0b_0c0d_0e0f_1011,
                          64'hcafe_f00d_beef_abcd, 64'h0000_0001_0002_0003};
        cases[2].reps  = 4'd15;
        cases[2].bp    = 1'b1;
    endtask

    initial begin
        vpu_pkg::apb_data_t rd;
        lfsr         = 32'hc6e3;
        stall_cycles = 0;
        i_rst_n      = 1'b0;
        i_apb        = '0;
        i_tdata      = '0;
        i_tvalid     = 1'b0;
        i_tready     = 1'b1;
        load_table();
        repeat (8) @(negedge clk);
        i_rst_n = 1'b1;

        @(negedge clk);
        check_bit("o_tvalid", o_tvalid, 1'b0);
        check_bit("o_tready", o_tready, 1'b0);   // run bit still clear
        for (int a = 0; a < 32; a++) begin
            apb_xfer(1'b0, vpu_pkg::apb_addr_t'(a), '0, rd);
            check_data($sformatf("apb word %0d", a), rd, '0);
        end

        write_verify(vpu_pkg::ADDR_CTRL, 32'h1, 32'h1);
        write_verify(vpu_pkg::NUM_REGS, 32'hdead_beef, '0);   // unmapped
        write_verify(31, 32'h0000_5a5a, '0);

        for (int i = 0; i < N_CASES; i++) begin
            run_case(cases[i]);
        end

        // stopped core accepts nothing
        write_verify(vpu_pkg::ADDR_CTRL, 32'h0, 32'h0);
        @(negedge clk);
        i_tvalid = 1'b1;
        i_tdata  = 64'h1111_2222_3333_4444;
        repeat (20) begin
            @(negedge clk);
            check_bit("o_tready", o_tready, 1'b0);
            check_bit("o_tvalid", o_tvalid, 1'b0);
        end
        i_tvalid = 1'b0;

        $display("All tests passed");
        $finish;
    end

endmodule

// File: data_path.f
vpu_pkg.sv
sync_fifo.sv
stream_ingress.sv
mac_column.sv
stream_egress.sv
coef_regs.sv
data_path.sv
tb_data_path.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_data_path
RTL_TOP   ?= data_path
FILELIST  ?= data_path.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the simulator exits non-zero on $fatal
run: build
	./$(BUILD_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
